/* filelist.f */
source/sb_pkg.sv
source/sb_prio_select.sv
source/sb_queue.sv
source/sb_clobber.sv
source/sb_forward.sv
source/scoreboard.sv
test/tb_scoreboard.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_scoreboard \
  -Mdir obj_dir -o sim_scoreboard > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_scoreboard > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
exit 1

/* source/sb_clobber.sv */
// register clobber map, names the unit that will write each architectural register
`timescale 1ns/1ps
`default_nettype none

module sb_clobber (
  input  sb_pkg::sb_entry_t [sb_pkg::SB_ENTRIES-1:0] entries_i,
  input  logic              [sb_pkg::SB_ENTRIES-1:0] issued_i,
  output sb_pkg::fu_t       [sb_pkg::NR_REGS-1:0]    rd_clobber_o
);
  import sb_pkg::*;

  logic [NR_REGS-1:0][SB_ENTRIES-1:0] clobber_req;
  logic [NR_REGS-1:0]                 clobber_hit;
  fu_t  [NR_REGS-1:0]                 clobber_fu;
  fu_t  [SB_ENTRIES-1:0]              entry_fu;

  // one request per issued slot whose rd is this register
  // x0 never gets a request
  always_comb begin
    for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
      entry_fu[i] = entries_i[i].fu;
    end
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
        clobber_req[r][i] = (r != 0) && issued_i[i] &&
                            (entries_i[i].rd == reg_addr_t'(r));
      end
    end
  end

  for (genvar r = 0; r < NR_REGS; r++) begin : gen_reg
    sb_prio_select #(
      .NUM_IN    (SB_ENTRIES),
      .payload_t (fu_t)
    ) i_sel_fu (
      .req_i   (clobber_req[r]),
      .data_i  (entry_fu),
      .valid_o (clobber_hit[r]),
      .data_o  (clobber_fu[r])
    );

    // free register reads NONE
    assign rd_clobber_o[r] = clobber_hit[r] ? clobber_fu[r] : NONE;
  end

endmodule

`default_nettype wire

/* source/sb_forward.sv */
// operand forwarding for rs1 and rs2 from result buses and finished slots
`timescale 1ns/1ps
`default_nettype none

module sb_forward #(
  parameter int unsigned NR_WB_PORTS = 2
) (
  input  sb_pkg::sb_entry_t [sb_pkg::SB_ENTRIES-1:0] entries_i,
  input  logic              [sb_pkg::SB_ENTRIES-1:0] issued_i,
  input  sb_pkg::wb_t       [NR_WB_PORTS-1:0]        wb_i,
  input  sb_pkg::reg_addr_t                          rs1_i,
  input  sb_pkg::reg_addr_t                          rs2_i,
  output sb_pkg::xlen_t                              rs1_o,
  output logic                                       rs1_valid_o,
  output sb_pkg::xlen_t                              rs2_o,
  output logic                                       rs2_valid_o
);
  import sb_pkg::*;

  // result buses sit below the slots and so win
  localparam int unsigned NUM_SRC = NR_WB_PORTS + SB_ENTRIES;

  reg_addr_t [1:0]                       rs_addr;
  logic      [1:0][NUM_SRC-1:0]          fwd_req;
  xlen_t     [NUM_SRC-1:0]               fwd_data;
  logic      [1:0]                       fwd_hit;
  xlen_t     [1:0]                       fwd_val;

  assign rs_addr = {rs2_i, rs1_i};

  always_comb begin
    for (int unsigned op = 0; op < 2; op++) begin
      // a bus counts when the slot it writes targets this operand
      for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
        fwd_req[op][p] = wb_i[p].valid && issued_i[wb_i[p].trans_id] &&
                         (entries_i[wb_i[p].trans_id].rd == rs_addr[op]);
      end
      // finished slots still waiting for commit
      for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
        fwd_req[op][NR_WB_PORTS+i] = issued_i[i] && entries_i[i].valid &&
                                     (entries_i[i].rd == rs_addr[op]);
      end
    end
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      fwd_data[p] = wb_i[p].data;
    end
    for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
      fwd_data[NR_WB_PORTS+i] = entries_i[i].result;
    end
  end

  for (genvar op = 0; op < 2; op++) begin : gen_operand
    sb_prio_select #(
      .NUM_IN    (NUM_SRC),
      .payload_t (xlen_t)
    ) i_sel_operand (
      .req_i   (fwd_req[op]),
      .data_i  (fwd_data),
      .valid_o (fwd_hit[op]),
      .data_o  (fwd_val[op])
    );
  end

  // x0 is hard zero and never forwarded
  assign rs1_o       = fwd_val[0];
  assign rs1_valid_o = fwd_hit[0] & (|rs1_i);
  assign rs2_o       = fwd_val[1];
  assign rs2_valid_o = fwd_hit[1] & (|rs2_i);

endmodule

`default_nettype wire

/* source/sb_pkg.sv */
// scoreboard package with queue sizes, functional unit codes and entry records
`default_nettype none

package sb_pkg;

  // architectural register file
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned NR_REGS       = 2 ** REG_ADDR_BITS;
  localparam int unsigned XLEN          = 32;

  // queue depth must stay a power of two so the pointers wrap for free
  localparam int unsigned SB_ENTRIES    = 8;
  localparam int unsigned TRANS_ID_BITS = $clog2(SB_ENTRIES);

  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

  // unit that will produce the result, NONE finishes without write-back
  typedef enum logic [2:0] {
    NONE  = 3'd0,
    ALU   = 3'd1,
    LOAD  = 3'd2,
    STORE = 3'd3,
    MULT  = 3'd4,
    CSR   = 3'd5
  } fu_t;

  // one queue slot as seen by issue and commit
  typedef struct packed {
    trans_id_t trans_id;
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    logic      valid;     // result present
  } sb_entry_t;

  // result bus from one functional unit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
  } wb_t;

endpackage

`default_nettype wire

/* source/sb_prio_select.sv */
// fixed-priority selector, passes on the payload of the lowest-index requester
`timescale 1ns/1ps
`default_nettype none

module sb_prio_select #(
  parameter int unsigned NUM_IN = 2,
  parameter type payload_t = logic
) (
  input  logic     [NUM_IN-1:0] req_i,
  input  payload_t [NUM_IN-1:0] data_i,
  output logic                  valid_o,
  output payload_t              data_o
);

  // walk from the top down so that the lowest index is written last
  always_comb begin
    valid_o = 1'b0;
    data_o  = payload_t'('0);
    for (int i = NUM_IN - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        valid_o = 1'b1;
        data_o  = data_i[i];
      end
    end
  end

endmodule

`default_nettype wire

/* source/sb_queue.sv */
// scoreboard queue, tracks decoded entries from insert through issue, write-back and commit
`timescale 1ns/1ps
`default_nettype none

module sb_queue #(
  parameter int unsigned NR_WB_PORTS     = 2,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      flush_i,
  input  logic                                      unresolved_branch_i,
  // decode side
  input  sb_pkg::sb_entry_t                         decoded_instr_i,
  input  logic                                      decoded_instr_valid_i,
  output logic                                      decoded_instr_ack_o,
  // issue side
  output sb_pkg::sb_entry_t                         issue_instr_o,
  output logic                                      issue_instr_valid_o,
  input  logic                                      issue_ack_i,
  // functional unit results
  input  sb_pkg::wb_t       [NR_WB_PORTS-1:0]       wb_i,
  // commit side
  output sb_pkg::sb_entry_t [NR_COMMIT_PORTS-1:0]   commit_instr_o,
  input  logic              [NR_COMMIT_PORTS-1:0]   commit_ack_i,
  output logic                                      sb_full_o,
  // slot view for clobber and forwarding
  output sb_pkg::sb_entry_t [sb_pkg::SB_ENTRIES-1:0] entries_o,
  output logic              [sb_pkg::SB_ENTRIES-1:0] issued_o
);
  import sb_pkg::*;

  // payload storage, valid and issued live in separate vectors
  sb_entry_t [SB_ENTRIES-1:0] mem_q;
  sb_entry_t [SB_ENTRIES-1:0] mem_d;
  sb_entry_t [SB_ENTRIES-1:0] entries;
  logic      [SB_ENTRIES-1:0] issued_q, issued_d;
  logic      [SB_ENTRIES-1:0] valid_q, valid_d;

  trans_id_t insert_ptr_q, insert_ptr_d;
  trans_id_t issue_ptr_q, issue_ptr_d;
  trans_id_t commit_ptr_q, commit_ptr_d;
  trans_id_t insert_cnt_q, insert_cnt_d;
  trans_id_t issue_cnt_q, issue_cnt_d;
  trans_id_t num_commit;

  logic full;
  logic synced;
  logic insert_en;
  logic issue_en;

  // all ones means seven outstanding, one slot always stays free
  assign full      = &insert_cnt_q;
  assign synced    = (insert_cnt_q == issue_cnt_q);
  assign sb_full_o = full;

  // merge payload with the live valid bit
  always_comb begin
    for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
      entries[i]       = mem_q[i];
      entries[i].valid = valid_q[i];
    end
  end

  assign entries_o = entries;
  assign issued_o  = issued_q;

  // ------------------------------------------------------------------
  // decode and issue handshake
  // ------------------------------------------------------------------
  // when nothing waits in the queue the decoded instruction bypasses it
  always_comb begin
    issue_instr_o          = synced ? decoded_instr_i : entries[issue_ptr_q];
    issue_instr_o.trans_id = insert_ptr_q;
    issue_instr_valid_o    = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
    decoded_instr_ack_o    = ~full & (~synced | issue_ack_i);
  end

  assign insert_en = decoded_instr_valid_i & decoded_instr_ack_o;
  // while synced only the instruction being inserted can be issued
  assign issue_en  = issue_ack_i & (~synced | insert_en);

  // commit ports look at consecutive slots from the commit pointer
  always_comb begin
    trans_id_t cidx;
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      cidx                       = commit_ptr_q + trans_id_t'(k);
      commit_instr_o[k]          = entries[cidx];
      commit_instr_o[k].trans_id = cidx;
    end
  end

  // acks are contiguous so a count is enough to advance
  always_comb begin
    num_commit = '0;
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        num_commit = num_commit + trans_id_t'(1);
      end
    end
  end

  // ------------------------------------------------------------------
  // next state of the slots
  // ------------------------------------------------------------------
  always_comb begin
    trans_id_t cidx;
    mem_d    = mem_q;
    issued_d = issued_q;
    valid_d  = valid_q;

    // new entry at the insert pointer, result still missing
    if (insert_en) begin
      mem_d[insert_ptr_q]          = decoded_instr_i;
      mem_d[insert_ptr_q].trans_id = insert_ptr_q;
      valid_d[insert_ptr_q]        = 1'b0;
    end

    if (issue_en) begin
      issued_d[issue_ptr_q] = 1'b1;
    end

    // no unit to wait for, done once issued
    for (int unsigned i = 0; i < SB_ENTRIES; i++) begin
      if (issued_q[i] && mem_q[i].fu == NONE) begin
        valid_d[i] = 1'b1;
      end
    end

    // stale results for slots no longer issued are dropped
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && issued_q[wb_i[p].trans_id]) begin
        valid_d[wb_i[p].trans_id]      = 1'b1;
        mem_d[wb_i[p].trans_id].result = wb_i[p].data;
      end
    end

    // retired slots are free again
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      cidx = commit_ptr_q + trans_id_t'(k);
      if (commit_ack_i[k]) begin
        issued_d[cidx] = 1'b0;
        valid_d[cidx]  = 1'b0;
      end
    end

    if (flush_i) begin
      issued_d = '0;
      valid_d  = '0;
    end
  end

  // pointers and counters
  assign insert_ptr_d = flush_i ? '0 : insert_ptr_q + trans_id_t'(insert_en);
  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + num_commit;
  assign insert_cnt_d = flush_i ? '0 : insert_cnt_q - num_commit + trans_id_t'(insert_en);
  assign issue_cnt_d  = flush_i ? '0 : issue_cnt_q - num_commit + trans_id_t'(issue_en);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q     <= '0;
      valid_q      <= '0;
      insert_ptr_q <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      insert_cnt_q <= '0;
      issue_cnt_q  <= '0;
    end else begin
      issued_q     <= issued_d;
      valid_q      <= valid_d;
      insert_ptr_q <= insert_ptr_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      insert_cnt_q <= insert_cnt_d;
      issue_cnt_q  <= issue_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    mem_q <= mem_d;
  end

endmodule

`default_nettype wire

/* source/scoreboard.sv */
// issue scoreboard top, joins the queue with the clobber map and operand forwarding
`timescale 1ns/1ps
`default_nettype none

module scoreboard #(
  parameter int unsigned NR_WB_PORTS     = 2,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     flush_i,
  input  logic                                     unresolved_branch_i,
  output logic                                     sb_full_o,
  // decode and issue
  input  sb_pkg::sb_entry_t                        decoded_instr_i,
  input  logic                                     decoded_instr_valid_i,
  output logic                                     decoded_instr_ack_o,
  output sb_pkg::sb_entry_t                        issue_instr_o,
  output logic                                     issue_instr_valid_o,
  input  logic                                     issue_ack_i,
  // commit
  output sb_pkg::sb_entry_t [NR_COMMIT_PORTS-1:0]  commit_instr_o,
  input  logic              [NR_COMMIT_PORTS-1:0]  commit_ack_i,
  // results from the units
  input  sb_pkg::wb_t       [NR_WB_PORTS-1:0]      wb_i,
  // operand reads
  input  sb_pkg::reg_addr_t                        rs1_i,
  output sb_pkg::xlen_t                            rs1_o,
  output logic                                     rs1_valid_o,
  input  sb_pkg::reg_addr_t                        rs2_i,
  output sb_pkg::xlen_t                            rs2_o,
  output logic                                     rs2_valid_o,
  output sb_pkg::fu_t       [sb_pkg::NR_REGS-1:0]  rd_clobber_o
);
  import sb_pkg::*;

  sb_entry_t [SB_ENTRIES-1:0] entries;
  logic      [SB_ENTRIES-1:0] issued;

  sb_queue #(
    .NR_WB_PORTS     (NR_WB_PORTS),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) i_queue (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .wb_i                  (wb_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .sb_full_o             (sb_full_o),
    .entries_o             (entries),
    .issued_o              (issued)
  );

  sb_clobber i_clobber (
    .entries_i    (entries),
    .issued_i     (issued),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_forward #(
    .NR_WB_PORTS (NR_WB_PORTS)
  ) i_forward (
    .entries_i   (entries),
    .issued_i    (issued),
    .wb_i        (wb_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rs1_o       (rs1_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_o       (rs2_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

`default_nettype wire

/* test/tb_scoreboard.sv */
// testbench for the issue scoreboard, table-driven against an in-order reference model
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard;
  import sb_pkg::*;

  localparam int unsigned NR_WB_PORTS     = 2;
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int          MAX_OUT         = SB_ENTRIES - 1;

  typedef enum logic [2:0] {OP_IDLE, OP_INSERT, OP_BRANCH, OP_WB, OP_COMMIT, OP_FLUSH} op_e;

  // one table row: operation, its fields, operand reads and the expected full flag
  typedef struct packed {
    op_e       op;
    fu_t       fu;
    reg_addr_t rd;
    int        arg;       // write-back slot or number of commit acks
    int        port;      // write-back port
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      exp_full;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic flush_i, unresolved_branch_i, sb_full_o;
  sb_entry_t decoded_instr_i, issue_instr_o;
  logic decoded_instr_valid_i, decoded_instr_ack_o, issue_instr_valid_o, issue_ack_i;
  sb_entry_t [NR_COMMIT_PORTS-1:0] commit_instr_o;
  logic      [NR_COMMIT_PORTS-1:0] commit_ack_i;
  wb_t       [NR_WB_PORTS-1:0]     wb_i;
  reg_addr_t rs1_i, rs2_i;
  xlen_t     rs1_o, rs2_o;
  logic      rs1_valid_o, rs2_valid_o;
  fu_t       [NR_REGS-1:0]         rd_clobber_o;

  // reference model, slots in queue order
  fu_t       m_fu     [SB_ENTRIES];
  reg_addr_t m_rd     [SB_ENTRIES];
  xlen_t     m_res    [SB_ENTRIES];
  logic      m_valid  [SB_ENTRIES];
  logic      m_issued [SB_ENTRIES];
  trans_id_t m_head, m_tail;
  int        m_count;

  row_t rows[$];
  int   errors = 0;
  int   cur_row = 0;
  int   cycles = 0;
  int   cycle_limit = 0;

  scoreboard #(
    .NR_WB_PORTS     (NR_WB_PORTS),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) DUT (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .sb_full_o             (sb_full_o),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .wb_i                  (wb_i),
    .rs1_i                 (rs1_i),
    .rs1_o                 (rs1_o),
    .rs1_valid_o           (rs1_valid_o),
    .rs2_i                 (rs2_i),
    .rs2_o                 (rs2_o),
    .rs2_valid_o           (rs2_valid_o),
    .rd_clobber_o          (rd_clobber_o)
  );

  always #50 clk_i = ~clk_i;

  // run limit scales with the table
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the operation table did not complete", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------
  task automatic check_entry(string name, sb_entry_t got, sb_entry_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s in row %0d: got %h, expected %h", name, cur_row, got, exp);
    end
  endtask

  task automatic check_fu(string name, fu_t got, fu_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s in row %0d: got %h, expected %h", name, cur_row, got, exp);
    end
  endtask

  task automatic check_data(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s in row %0d: got %h, expected %h", name, cur_row, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s in row %0d: got %h, expected %h", name, cur_row, got, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------
  function automatic sb_entry_t make_entry(trans_id_t tid, fu_t fu, reg_addr_t rd,
                                           xlen_t res, logic valid);
    sb_entry_t e;
    e.trans_id = tid;
    e.fu       = fu;
    e.rd       = rd;
    e.result   = res;
    e.valid    = valid;
    return e;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < SB_ENTRIES; i++) begin
      m_valid[i]  = 1'b0;
      m_issued[i] = 1'b0;
    end
    m_head  = '0;
    m_tail  = '0;
    m_count = 0;
  endtask

  // state change at one rising edge, from the inputs held during the cycle
  task automatic model_edge();
    logic      old_iss [SB_ENTRIES];
    logic      do_insert;
    int        n;
    trans_id_t slot;
    if (flush_i) begin
      model_reset();
      return;
    end
    do_insert = decoded_instr_valid_i && issue_ack_i && (m_count < MAX_OUT);
    for (int i = 0; i < SB_ENTRIES; i++) begin
      old_iss[i] = m_issued[i];
      // no unit to wait for
      if (old_iss[i] && m_fu[i] == NONE) m_valid[i] = 1'b1;
    end
    for (int p = 0; p < NR_WB_PORTS; p++) begin
      slot = wb_i[p].trans_id;
      if (wb_i[p].valid && old_iss[slot]) begin
        m_valid[slot] = 1'b1;
        m_res[slot]   = wb_i[p].data;
      end
    end
    n = 0;
    for (int k = 0; k < NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        slot           = m_head + trans_id_t'(k);
        m_issued[slot] = 1'b0;
        m_valid[slot]  = 1'b0;
        n++;
      end
    end
    m_head  = m_head + trans_id_t'(n);
    m_count = m_count - n;
    // synced insert is issued in the same cycle
    if (do_insert) begin
      m_fu[m_tail]     = decoded_instr_i.fu;
      m_rd[m_tail]     = decoded_instr_i.rd;
      m_res[m_tail]    = decoded_instr_i.result;
      m_valid[m_tail]  = 1'b0;
      m_issued[m_tail] = 1'b1;
      m_tail           = m_tail + trans_id_t'(1);
      m_count++;
    end
  endtask

  // lowest slot index writing the register, x0 never
  function automatic fu_t exp_clobber(int r);
    fu_t  f;
    logic found;
    f     = NONE;
    found = 1'b0;
    for (int i = 0; i < SB_ENTRIES; i++) begin
      if (!found && r != 0 && m_issued[i] && m_rd[i] == reg_addr_t'(r)) begin
        f     = m_fu[i];
        found = 1'b1;
      end
    end
    return f;
  endfunction

  // result buses first in port order, then finished slots in index order
  function automatic logic exp_fwd(reg_addr_t addr, output xlen_t data);
    logic      hit;
    trans_id_t tid;
    hit  = 1'b0;
    data = '0;
    for (int p = 0; p < NR_WB_PORTS; p++) begin
      tid = wb_i[p].trans_id;
      if (!hit && wb_i[p].valid && m_issued[tid] && m_rd[tid] == addr) begin
        hit  = 1'b1;
        data = wb_i[p].data;
      end
    end
    for (int i = 0; i < SB_ENTRIES; i++) begin
      if (!hit && m_issued[i] && m_valid[i] && m_rd[i] == addr) begin
        hit  = 1'b1;
        data = m_res[i];
      end
    end
    return hit && (addr != '0);
  endfunction

  // ------------------------------------------------------------------
  // stimulus and checks per row
  // ------------------------------------------------------------------
  task automatic add_row(op_e op, fu_t fu, reg_addr_t rd, int arg, int port,
                         reg_addr_t rs1, reg_addr_t rs2, logic exp_full);
    row_t r;
    r.op       = op;
    r.fu       = fu;
    r.rd       = rd;
    r.arg      = arg;
    r.port     = port;
    r.rs1      = rs1;
    r.rs2      = rs2;
    r.exp_full = exp_full;
    rows.push_back(r);
  endtask

  task automatic drive_row(row_t row);
    decoded_instr_valid_i = 1'b0;
    unresolved_branch_i   = 1'b0;
    issue_ack_i           = 1'b0;
    wb_i                  = '0;
    commit_ack_i          = '0;
    flush_i               = 1'b0;
    decoded_instr_i       = make_entry('0, row.fu, row.rd, '0, 1'b0);
    rs1_i                 = row.rs1;
    rs2_i                 = row.rs2;
    case (row.op)
      OP_INSERT: begin
        decoded_instr_valid_i = 1'b1;
        // ack only while the issue valid can be high
        issue_ack_i           = (m_count < MAX_OUT);
      end
      OP_BRANCH: begin
        decoded_instr_valid_i = 1'b1;
        unresolved_branch_i   = 1'b1;
      end
      OP_WB: begin
        wb_i[row.port].valid    = 1'b1;
        wb_i[row.port].trans_id = trans_id_t'(row.arg);
        wb_i[row.port].data     = $urandom;
      end
      OP_COMMIT: begin
        for (int k = 0; k < NR_COMMIT_PORTS; k++) commit_ack_i[k] = (k < row.arg);
      end
      OP_FLUSH: flush_i = 1'b1;
      default: ;
    endcase
  endtask

  task automatic check_outputs(row_t row);
    trans_id_t slot;
    xlen_t     d;
    logic      v;
    check_bit("sb_full_o", sb_full_o, m_count == MAX_OUT);
    check_bit("sb_full_o vs table", sb_full_o, row.exp_full);
    for (int k = 0; k < NR_COMMIT_PORTS; k++) begin
      slot = m_head + trans_id_t'(k);
      check_bit($sformatf("commit_instr_o[%0d].valid", k), commit_instr_o[k].valid,
                m_valid[slot]);
      if (m_valid[slot]) begin
        check_entry($sformatf("commit_instr_o[%0d]", k), commit_instr_o[k],
                    make_entry(slot, m_fu[slot], m_rd[slot], m_res[slot], 1'b1));
      end
    end
    for (int r = 0; r < NR_REGS; r++) begin
      check_fu($sformatf("rd_clobber_o[%0d]", r), rd_clobber_o[r], exp_clobber(r));
    end
    v = exp_fwd(row.rs1, d);
    check_bit("rs1_valid_o", rs1_valid_o, v);
    if (v) check_data("rs1_o", rs1_o, d);
    v = exp_fwd(row.rs2, d);
    check_bit("rs2_valid_o", rs2_valid_o, v);
    if (v) check_data("rs2_o", rs2_o, d);
    // decode and issue handshake
    if (row.op == OP_INSERT || row.op == OP_BRANCH) begin
      v = (row.op == OP_INSERT) && (m_count < MAX_OUT);
      check_bit("decoded_instr_ack_o", decoded_instr_ack_o, v);
      check_bit("issue_instr_valid_o", issue_instr_valid_o, v);
      check_entry("issue_instr_o", issue_instr_o, make_entry(m_tail, row.fu, row.rd, '0, 1'b0));
    end
  endtask

  task automatic build_table();
    add_row(OP_IDLE,   NONE,  0,  0, 0, 0, 0, 1'b0);
    // four inserts into slots 0 to 3, x0 target on the NONE entry
    add_row(OP_INSERT, ALU,   5,  0, 0, 0, 0, 1'b0);
    add_row(OP_INSERT, LOAD,  7,  0, 0, 5, 7, 1'b0);
    add_row(OP_INSERT, NONE,  0,  0, 0, 0, 7, 1'b0);
    add_row(OP_INSERT, ALU,   5,  0, 0, 5, 0, 1'b0);
    add_row(OP_BRANCH, ALU,   9,  0, 0, 5, 7, 1'b0);
    // results, with same-cycle bus forwarding
    add_row(OP_WB,     NONE,  0,  0, 0, 5, 7, 1'b0);
    add_row(OP_IDLE,   NONE,  0,  0, 0, 5, 0, 1'b0);
    add_row(OP_WB,     NONE,  0,  3, 1, 5, 7, 1'b0);
    add_row(OP_WB,     NONE,  0,  1, 0, 7, 5, 1'b0);
    add_row(OP_COMMIT, NONE,  0,  2, 0, 5, 7, 1'b0);
    add_row(OP_IDLE,   NONE,  0,  0, 0, 5, 7, 1'b0);
    add_row(OP_COMMIT, NONE,  0,  2, 0, 5, 0, 1'b0);
    add_row(OP_IDLE,   NONE,  0,  0, 0, 5, 7, 1'b0);
    // fill up to seven outstanding, wrapping the pointers
    add_row(OP_INSERT, MULT,  1,  0, 0, 0, 0, 1'b0);
    add_row(OP_INSERT, STORE, 2,  0, 0, 1, 0, 1'b0);
    add_row(OP_INSERT, CSR,   3,  0, 0, 1, 2, 1'b0);
    add_row(OP_INSERT, LOAD,  4,  0, 0, 1, 0, 1'b0);
    add_row(OP_INSERT, ALU,   6,  0, 0, 2, 0, 1'b0);
    add_row(OP_INSERT, MULT,  8,  0, 0, 0, 4, 1'b0);
    add_row(OP_INSERT, CSR,   9,  0, 0, 0, 0, 1'b0);
    add_row(OP_INSERT, CSR,   10, 0, 0, 9, 0, 1'b1);
    add_row(OP_WB,     NONE,  0,  4, 0, 1, 3, 1'b1);
    add_row(OP_FLUSH,  NONE,  0,  0, 0, 1, 0, 1'b1);
    add_row(OP_IDLE,   NONE,  0,  0, 0, 1, 3, 1'b0);
    add_row(OP_INSERT, ALU,   3,  0, 0, 0, 0, 1'b0);
    add_row(OP_IDLE,   NONE,  0,  0, 0, 3, 0, 1'b0);
  endtask

  initial begin : main
    void'($urandom(32'h479f));
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    unresolved_branch_i   = 1'b0;
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    issue_ack_i           = 1'b0;
    commit_ack_i          = '0;
    wb_i                  = '0;
    rs1_i                 = '0;
    rs2_i                 = '0;
    model_reset();
    build_table();
    cycle_limit = 20 * rows.size() + 50;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    foreach (rows[i]) begin
      @(posedge clk_i);
      model_edge();
      #1;
      cur_row = i;
      drive_row(rows[i]);
      #1;
      check_outputs(rows[i]);
    end
    $display("finished %0d rows with %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
